/* rtl/net_cross_defs.svh */
`ifndef NET_CROSS_DEFS_SVH
`define NET_CROSS_DEFS_SVH

// User regions behind the crossing
`define N_REGIONS        4
`define REGION_BITS      2

// Field widths
`define VADDR_BITS       48
`define REQ_LEN_BITS     28
`define CMD_LEN_BITS     8
`define DATA_BITS        64

// Each crossing FIFO holds 16 entries
`define FIFO_DEPTH_LOG2  4

// Outstanding read bursts tracked by the router
`define ORDER_DEPTH_LOG2 3

`endif

/* rtl/net_cross_pkg.sv */
`include "net_cross_defs.svh"

package net_cross_pkg;

    // Host RDMA request
    // Region field is overwritten by the arbiter with the source index
    typedef struct packed {
        logic [`REGION_BITS-1:0]  region;
        logic [`VADDR_BITS-1:0]   vaddr;
        logic [`REQ_LEN_BITS-1:0] len;
    } req_t;

    // Read command from the network stack
    // Length counts beats, 1 to 255
    typedef struct packed {
        logic [`REGION_BITS-1:0]  region;
        logic [`VADDR_BITS-1:0]   vaddr;
        logic [`CMD_LEN_BITS-1:0] len;
    } cmd_t;

    // One beat of read data
    typedef struct packed {
        logic [`DATA_BITS-1:0] data;
        logic                  last;
    } beat_t;

endpackage

/* rtl/async_stream_fifo.sv */
`timescale 1ns/1ps
`include "net_cross_defs.svh"

module async_stream_fifo #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     wr_clk,
    input  logic     rd_clk,
    input  logic     rst_n,

    // Write side, wr_clk domain
    input  logic     wr_valid,
    output logic     wr_ready,
    input  payload_t wr_data,

    // Read side, rd_clk domain
    output logic     rd_valid,
    input  logic     rd_ready,
    output payload_t rd_data
);

    localparam int AW    = `FIFO_DEPTH_LOG2;
    localparam int DEPTH = 1 << AW;

    payload_t mem [DEPTH];

    // Write domain pointers
    logic [AW:0] wr_bin;
    logic [AW:0] wr_bin_next;
    logic [AW:0] wr_gray;
    logic [AW:0] wr_gray_next;
    logic [AW:0] rd_gray_s1;
    logic [AW:0] rd_gray_s2;
    logic        wr_fire;

    // Read domain pointers
    logic [AW:0] rd_bin;
    logic [AW:0] rd_bin_next;
    logic [AW:0] rd_gray;
    logic [AW:0] wr_gray_s1;
    logic [AW:0] wr_gray_s2;
    logic        rd_fire;

    function automatic logic [AW:0] bin2gray(input logic [AW:0] bin);
        return bin ^ (bin >> 1);
    endfunction

    assign wr_fire      = wr_valid && wr_ready;
    assign wr_bin_next  = wr_bin + (AW + 1)'(wr_fire);
    assign wr_gray_next = bin2gray(wr_bin_next);

    always_ff @(posedge wr_clk) begin
        if (wr_fire) begin
            mem[wr_bin[AW-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge wr_clk) begin
        if (!rst_n) begin
            wr_bin     <= '0;
            wr_gray    <= '0;
            rd_gray_s1 <= '0;
            rd_gray_s2 <= '0;
            wr_ready   <= 1'b0;
        end else begin
            wr_bin     <= wr_bin_next;
            wr_gray    <= wr_gray_next;
            rd_gray_s1 <= rd_gray;
            rd_gray_s2 <= rd_gray_s1;
            // Full when the next write pointer sits one lap ahead of the read pointer
            wr_ready   <= (wr_gray_next != {~rd_gray_s2[AW:AW-1], rd_gray_s2[AW-2:0]});
        end
    end

    // Entry visible once the write pointer has passed both sync stages
    assign rd_valid    = (rd_gray != wr_gray_s2);
    assign rd_data     = mem[rd_bin[AW-1:0]];
    assign rd_fire     = rd_valid && rd_ready;
    assign rd_bin_next = rd_bin + (AW + 1)'(rd_fire);

    always_ff @(posedge rd_clk) begin
        if (!rst_n) begin
            rd_bin     <= '0;
            rd_gray    <= '0;
            wr_gray_s1 <= '0;
            wr_gray_s2 <= '0;
        end else begin
            rd_bin     <= rd_bin_next;
            rd_gray    <= bin2gray(rd_bin_next);
            wr_gray_s1 <= wr_gray;
            wr_gray_s2 <= wr_gray_s1;
        end
    end

endmodule

/* rtl/req_arbiter.sv */
`timescale 1ns/1ps
`include "net_cross_defs.svh"

module req_arbiter (
    input  logic                    aclk,
    input  logic                    rst_n,

    input  logic [`N_REGIONS-1:0]   in_valid,
    output logic [`N_REGIONS-1:0]   in_ready,
    input  net_cross_pkg::req_t     in_data [`N_REGIONS],

    output logic                    out_valid,
    input  logic                    out_ready,
    output net_cross_pkg::req_t     out_data
);

    logic [`REGION_BITS-1:0] rr_ptr;
    logic [`REGION_BITS-1:0] scan_idx;
    logic [`REGION_BITS-1:0] pick;
    logic                    pick_found;
    logic                    locked;
    logic [`REGION_BITS-1:0] lock_idx;
    logic [`REGION_BITS-1:0] grant;

    // First requester at or after the pointer
    always_comb begin
        pick       = rr_ptr;
        pick_found = 1'b0;
        scan_idx   = rr_ptr;
        for (int i = 0; i < `N_REGIONS; i++) begin
            scan_idx = rr_ptr + `REGION_BITS'(i);
            if (!pick_found && in_valid[scan_idx]) begin
                pick       = scan_idx;
                pick_found = 1'b1;
            end
        end
    end

    // A stalled grant stays put until it transfers
    assign grant     = locked ? lock_idx : pick;
    assign out_valid = in_valid[grant];

    always_comb begin
        out_data        = in_data[grant];
        out_data.region = grant;
        for (int i = 0; i < `N_REGIONS; i++) begin
            in_ready[i] = out_ready && (grant == `REGION_BITS'(i));
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            rr_ptr   <= '0;
            locked   <= 1'b0;
            lock_idx <= '0;
        end else if (out_valid && out_ready) begin
            rr_ptr   <= grant + `REGION_BITS'(1);
            locked   <= 1'b0;
        end else if (out_valid) begin
            locked   <= 1'b1;
            lock_idx <= grant;
        end
    end

endmodule

/* rtl/rd_cmd_router.sv */
`timescale 1ns/1ps
`include "net_cross_defs.svh"

module rd_cmd_router (
    input  logic                    aclk,
    input  logic                    rst_n,

    // Commands from the crossing FIFO
    input  logic                    cmd_valid,
    output logic                    cmd_ready,
    input  net_cross_pkg::cmd_t     cmd_data,

    // Commands to the regions, data bus shared
    output logic [`N_REGIONS-1:0]   rd_cmd_valid,
    input  logic [`N_REGIONS-1:0]   rd_cmd_ready,
    output net_cross_pkg::cmd_t     rd_cmd_data,

    // Read data from the regions
    input  logic [`N_REGIONS-1:0]   rd_data_valid,
    output logic [`N_REGIONS-1:0]   rd_data_ready,
    input  net_cross_pkg::beat_t    rd_data_data [`N_REGIONS],

    // Ordered read data toward the crossing FIFO
    output logic                    out_valid,
    input  logic                    out_ready,
    output net_cross_pkg::beat_t    out_data
);

    localparam int QW    = `ORDER_DEPTH_LOG2;
    localparam int QSIZE = 1 << QW;

    // Ring of region indices, one per outstanding burst
    logic [`REGION_BITS-1:0] order_q [QSIZE];
    logic [QW:0]             wr_ptr;
    logic [QW:0]             rd_ptr;
    logic                    q_full;
    logic                    q_empty;
    logic [`REGION_BITS-1:0] head;
    logic                    cmd_fire;
    logic                    beat_fire;
    logic                    pop;

    assign q_empty = (wr_ptr == rd_ptr);
    assign q_full  = (wr_ptr[QW] != rd_ptr[QW]) && (wr_ptr[QW-1:0] == rd_ptr[QW-1:0]);
    assign head    = order_q[rd_ptr[QW-1:0]];

    // Command decode
    // A command waits while the queue has no room for its region index
    assign cmd_ready   = !q_full && rd_cmd_ready[cmd_data.region];
    assign rd_cmd_data = cmd_data;
    assign cmd_fire    = cmd_valid && cmd_ready;

    always_comb begin
        for (int i = 0; i < `N_REGIONS; i++) begin
            rd_cmd_valid[i] = cmd_valid && !q_full
                              && (cmd_data.region == `REGION_BITS'(i));
        end
    end

    // Return mux follows the head region only
    // Regions offering data early are held off until their turn
    assign out_valid = !q_empty && rd_data_valid[head];
    assign out_data  = rd_data_data[head];
    assign beat_fire = out_valid && out_ready;
    assign pop       = beat_fire && out_data.last;

    always_comb begin
        for (int i = 0; i < `N_REGIONS; i++) begin
            rd_data_ready[i] = !q_empty && out_ready && (head == `REGION_BITS'(i));
        end
    end

    always_ff @(posedge aclk) begin
        if (cmd_fire) begin
            order_q[wr_ptr[QW-1:0]] <= cmd_data.region;
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            wr_ptr <= wr_ptr + (QW + 1)'(cmd_fire);
            rd_ptr <= rd_ptr + (QW + 1)'(pop);
        end
    end

endmodule

/* rtl/network_clk_cross.sv */
`timescale 1ns/1ps
`include "net_cross_defs.svh"

module network_clk_cross (
    input  logic                    aclk,
    input  logic                    net_clk,
    input  logic                    rst_n,

    // Host requests per region, aclk
    input  logic [`N_REGIONS-1:0]   host_req_valid,
    output logic [`N_REGIONS-1:0]   host_req_ready,
    input  net_cross_pkg::req_t     host_req_data [`N_REGIONS],

    // Merged requests, net_clk
    output logic                    net_req_valid,
    input  logic                    net_req_ready,
    output net_cross_pkg::req_t     net_req_data,

    // Read commands from the network, net_clk
    input  logic                    net_rd_cmd_valid,
    output logic                    net_rd_cmd_ready,
    input  net_cross_pkg::cmd_t     net_rd_cmd_data,

    // Read commands to the regions, aclk
    output logic [`N_REGIONS-1:0]   rd_cmd_valid,
    input  logic [`N_REGIONS-1:0]   rd_cmd_ready,
    output net_cross_pkg::cmd_t     rd_cmd_data,

    // Read data from the regions, aclk
    input  logic [`N_REGIONS-1:0]   rd_data_valid,
    output logic [`N_REGIONS-1:0]   rd_data_ready,
    input  net_cross_pkg::beat_t    rd_data_data [`N_REGIONS],

    // Read data to the network, net_clk
    output logic                    net_rd_data_valid,
    input  logic                    net_rd_data_ready,
    output net_cross_pkg::beat_t    net_rd_data_data
);

    import net_cross_pkg::*;

    // Arbiter to request FIFO
    logic  req_arb_valid;
    logic  req_arb_ready;
    req_t  req_arb_data;

    // Command FIFO to router
    logic  cmd_arb_valid;
    logic  cmd_arb_ready;
    cmd_t  cmd_arb_data;

    // Router to data FIFO
    logic  data_arb_valid;
    logic  data_arb_ready;
    beat_t data_arb_data;

    // Host requests, aclk to net_clk
    req_arbiter inst_req_arbiter (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .in_valid  (host_req_valid),
        .in_ready  (host_req_ready),
        .in_data   (host_req_data),
        .out_valid (req_arb_valid),
        .out_ready (req_arb_ready),
        .out_data  (req_arb_data)
    );

    async_stream_fifo #(.payload_t(req_t)) inst_req_cross (
        .wr_clk   (aclk),
        .rd_clk   (net_clk),
        .rst_n    (rst_n),
        .wr_valid (req_arb_valid),
        .wr_ready (req_arb_ready),
        .wr_data  (req_arb_data),
        .rd_valid (net_req_valid),
        .rd_ready (net_req_ready),
        .rd_data  (net_req_data)
    );

    // Read commands, net_clk to aclk
    async_stream_fifo #(.payload_t(cmd_t)) inst_rd_cmd_cross (
        .wr_clk   (net_clk),
        .rd_clk   (aclk),
        .rst_n    (rst_n),
        .wr_valid (net_rd_cmd_valid),
        .wr_ready (net_rd_cmd_ready),
        .wr_data  (net_rd_cmd_data),
        .rd_valid (cmd_arb_valid),
        .rd_ready (cmd_arb_ready),
        .rd_data  (cmd_arb_data)
    );

    rd_cmd_router inst_rd_cmd_router (
        .aclk          (aclk),
        .rst_n         (rst_n),
        .cmd_valid     (cmd_arb_valid),
        .cmd_ready     (cmd_arb_ready),
        .cmd_data      (cmd_arb_data),
        .rd_cmd_valid  (rd_cmd_valid),
        .rd_cmd_ready  (rd_cmd_ready),
        .rd_cmd_data   (rd_cmd_data),
        .rd_data_valid (rd_data_valid),
        .rd_data_ready (rd_data_ready),
        .rd_data_data  (rd_data_data),
        .out_valid     (data_arb_valid),
        .out_ready     (data_arb_ready),
        .out_data      (data_arb_data)
    );

    // Read data, aclk to net_clk
    async_stream_fifo #(.payload_t(beat_t)) inst_rd_data_cross (
        .wr_clk   (aclk),
        .rd_clk   (net_clk),
        .rst_n    (rst_n),
        .wr_valid (data_arb_valid),
        .wr_ready (data_arb_ready),
        .wr_data  (data_arb_data),
        .rd_valid (net_rd_data_valid),
        .rd_ready (net_rd_data_ready),
        .rd_data  (net_rd_data_data)
    );

endmodule

/* test/network_clk_cross_sva.sv */
`timescale 1ns/1ps
`include "net_cross_defs.svh"

module network_clk_cross_sva (
    input logic                  aclk,
    input logic                  net_clk,
    input logic                  rst_n,
    input logic                  net_req_valid,
    input logic                  net_req_ready,
    input net_cross_pkg::req_t   net_req_data,
    input logic                  net_rd_data_valid,
    input logic                  net_rd_data_ready,
    input net_cross_pkg::beat_t  net_rd_data_data,
    input logic [`N_REGIONS-1:0] rd_cmd_valid
);

    // Stalled outputs hold valid and data
    req_hold: assert property (@(posedge net_clk) disable iff (!rst_n)
        net_req_valid && !net_req_ready |=> net_req_valid && $stable(net_req_data))
        else $error("net_req dropped or changed before its transfer");

    data_hold: assert property (@(posedge net_clk) disable iff (!rst_n)
        net_rd_data_valid && !net_rd_data_ready
        |=> net_rd_data_valid && $stable(net_rd_data_data))
        else $error("net_rd_data dropped or changed before its transfer");

    // One region addressed at a time on the shared command bus
    one_cmd: assert property (@(posedge aclk) disable iff (!rst_n)
        $onehot0(rd_cmd_valid))
        else $error("more than one rd_cmd_valid high");

    cmd_reset: assert property (@(posedge aclk) !rst_n |=> rd_cmd_valid == '0)
        else $error("rd_cmd_valid high after reset");

    net_reset: assert property (@(posedge net_clk)
        !rst_n |=> !net_req_valid && !net_rd_data_valid)
        else $error("network valid high after reset");

endmodule

/* test/network_clk_cross_tb.sv */
`timescale 1ns/1ps
`include "net_cross_defs.svh"

module network_clk_cross_tb;
    import net_cross_pkg::*;

    localparam int N_FAIR    = 4;
    localparam int N_REQ     = 40;
    localparam int N_CMD     = 60;
    localparam int MAX_BEATS = 8;
    localparam int ITEMS     = `N_REGIONS * (N_FAIR + N_REQ) + N_CMD * (MAX_BEATS + 1);
    localparam realtime WD_TIME = ITEMS * 40.0 + 2000.0;

    logic                  aclk = 1'b0;
    logic                  net_clk = 1'b0;
    logic                  rst_n = 1'b0;
    logic [`N_REGIONS-1:0] host_req_valid = '0;
    logic [`N_REGIONS-1:0] host_req_ready;
    req_t                  host_req_data [`N_REGIONS] = '{default: '0};
    logic                  net_req_valid;
    logic                  net_req_ready = 1'b0;
    req_t                  net_req_data;
    logic                  net_rd_cmd_valid = 1'b0;
    logic                  net_rd_cmd_ready;
    cmd_t                  net_rd_cmd_data = '0;
    logic [`N_REGIONS-1:0] rd_cmd_valid;
    logic [`N_REGIONS-1:0] rd_cmd_ready = '0;
    cmd_t                  rd_cmd_data;
    logic [`N_REGIONS-1:0] rd_data_valid = '0;
    logic [`N_REGIONS-1:0] rd_data_ready;
    beat_t                 rd_data_data [`N_REGIONS] = '{default: '0};
    logic                  net_rd_data_valid;
    logic                  net_rd_data_ready = 1'b0;
    beat_t                 net_rd_data_data;

    // Stimulus and expected values
    req_t  host_q [`N_REGIONS][$];
    req_t  exp_req [`N_REGIONS][$];
    cmd_t  cmd_q [$];
    cmd_t  exp_cmd [`N_REGIONS][$];
    cmd_t  region_q [`N_REGIONS][$];
    beat_t exp_beat [$];
    int    beat_idx [`N_REGIONS] = '{default: 0};

    logic [31:0] rng_state = 32'hf15;
    logic        throttle = 1'b0;
    logic        fair_mode = 1'b0;
    int          fair_count = 0;
    int          errs_init = 0;
    int          errs_req = 0;
    int          errs_data = 0;
    int          errs_cmd = 0;
    int          n_tests = 0;
    int          n_failed = 0;

    always #2 aclk = ~aclk;
    always #3 net_clk = ~net_clk;

    network_clk_cross u_dut (.*);

    bind network_clk_cross network_clk_cross_sva u_sva (.*);

    function automatic logic [31:0] xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic coin();
        logic [31:0] r;
        r = xorshift32();
        return r[0];
    endfunction

    // Beat value is address plus index with the region in the top bits
    function automatic beat_t beat_ref(input cmd_t cmd, input int idx);
        beat_t b;
        b.data = `DATA_BITS'(cmd.vaddr) + `DATA_BITS'(idx);
        b.data[`DATA_BITS-1 -: `REGION_BITS] = cmd.region;
        b.last = (idx == int'(cmd.len) - 1);
        return b;
    endfunction

    function automatic logic requests_pending();
        logic busy;
        busy = 1'b0;
        for (int i = 0; i < `N_REGIONS; i++) begin
            busy = busy || (exp_req[i].size() > 0) || (exp_cmd[i].size() > 0);
        end
        return busy || (exp_beat.size() > 0);
    endfunction

    task automatic load_requests(input int n);
        req_t r;
        for (int i = 0; i < `N_REGIONS; i++) begin
            for (int k = 0; k < n; k++) begin
                // Junk region field for the arbiter to overwrite
                r.region = `REGION_BITS'(xorshift32());
                r.vaddr  = `VADDR_BITS'({xorshift32(), xorshift32()});
                r.len    = `REQ_LEN_BITS'(xorshift32());
                host_q[i].push_back(r);
                r.region = `REGION_BITS'(i);
                exp_req[i].push_back(r);
            end
        end
    endtask

    task automatic load_commands();
        cmd_t c;
        for (int k = 0; k < N_CMD; k++) begin
            c.region = `REGION_BITS'(xorshift32());
            c.vaddr  = `VADDR_BITS'({xorshift32(), xorshift32()});
            c.len    = `CMD_LEN_BITS'(xorshift32() % MAX_BEATS + 1);
            cmd_q.push_back(c);
            exp_cmd[c.region].push_back(c);
            for (int b = 0; b < int'(c.len); b++) begin
                exp_beat.push_back(beat_ref(c, b));
            end
        end
    endtask

    task automatic check_req(input req_t got);
        int   r;
        req_t want;
        r = int'(got.region);
        if (exp_req[r].size() == 0) begin
            $display("request from region %0d arrived with none expected", r);
            errs_req++;
        end else begin
            want = exp_req[r].pop_front();
            if (got != want) begin
                $display("mismatch %s: expected %h actual %h",
                         fair_mode ? "fairness" : "request crossing", want, got);
                errs_req++;
            end
        end
        if (fair_mode) begin
            if (r != fair_count % `N_REGIONS) begin
                $display("mismatch fairness: expected %0d actual %0d",
                         fair_count % `N_REGIONS, r);
                errs_req++;
            end
            fair_count++;
        end
    endtask

    task automatic check_beat(input beat_t got);
        beat_t want;
        if (exp_beat.size() == 0) begin
            $display("read data beat arrived with none expected");
            errs_data++;
        end else begin
            want = exp_beat.pop_front();
            if (got != want) begin
                $display("mismatch ordered data return: expected %h actual %h", want, got);
                errs_data++;
            end
        end
    endtask

    task automatic check_cmd(input int i, input cmd_t got);
        cmd_t want;
        if (exp_cmd[i].size() == 0) begin
            $display("command reached region %0d with none expected", i);
            errs_cmd++;
        end else begin
            want = exp_cmd[i].pop_front();
            if (got != want) begin
                $display("mismatch command routing: expected %h actual %h", want, got);
                errs_cmd++;
            end
        end
    endtask

    task automatic report(input string name, input int n);
        n_tests++;
        if (n != 0) begin
            n_failed++;
        end
        $display("test %s: %s, %0d errors", name, (n == 0) ? "ok" : "FAILED", n);
    endtask

    // Host request sources hold each request on the bus until taken
    always @(posedge aclk) begin
        if (!rst_n) begin
            host_req_valid <= '0;
        end else begin
            for (int i = 0; i < `N_REGIONS; i++) begin
                if (host_req_valid[i] && host_req_ready[i]) begin
                    void'(host_q[i].pop_front());
                end
                if (!host_req_valid[i] || host_req_ready[i]) begin
                    if (host_q[i].size() > 0 && (!throttle || coin())) begin
                        host_req_valid[i] <= 1'b1;
                        host_req_data[i]  <= host_q[i][0];
                    end else begin
                        host_req_valid[i] <= 1'b0;
                    end
                end
            end
        end
    end

    // Region models may offer data before the router wants it
    always @(posedge aclk) begin
        if (!rst_n) begin
            rd_cmd_ready  <= '0;
            rd_data_valid <= '0;
        end else begin
            for (int i = 0; i < `N_REGIONS; i++) begin
                rd_cmd_ready[i] <= coin();
                if (rd_cmd_valid[i] && rd_cmd_ready[i]) begin
                    check_cmd(i, rd_cmd_data);
                    region_q[i].push_back(rd_cmd_data);
                end
                if (rd_data_valid[i] && rd_data_ready[i]) begin
                    beat_idx[i]++;
                    if (beat_idx[i] == int'(region_q[i][0].len)) begin
                        void'(region_q[i].pop_front());
                        beat_idx[i] = 0;
                    end
                end
                if (!rd_data_valid[i] || rd_data_ready[i]) begin
                    if (region_q[i].size() > 0 && coin()) begin
                        rd_data_valid[i] <= 1'b1;
                        rd_data_data[i]  <= beat_ref(region_q[i][0], beat_idx[i]);
                    end else begin
                        rd_data_valid[i] <= 1'b0;
                    end
                end
            end
        end
    end

    // Network side command source
    always @(posedge net_clk) begin
        if (!rst_n) begin
            net_rd_cmd_valid <= 1'b0;
        end else begin
            if (net_rd_cmd_valid && net_rd_cmd_ready) begin
                void'(cmd_q.pop_front());
            end
            if (!net_rd_cmd_valid || net_rd_cmd_ready) begin
                if (cmd_q.size() > 0 && coin()) begin
                    net_rd_cmd_valid <= 1'b1;
                    net_rd_cmd_data  <= cmd_q[0];
                end else begin
                    net_rd_cmd_valid <= 1'b0;
                end
            end
        end
    end

    // Compare network outputs against the expected queues
    always @(posedge net_clk) begin
        net_req_ready     <= !throttle || coin();
        net_rd_data_ready <= coin();
        if (rst_n && net_req_valid && net_req_ready) begin
            check_req(net_req_data);
        end
        if (rst_n && net_rd_data_valid && net_rd_data_ready) begin
            check_beat(net_rd_data_data);
        end
    end

    initial begin
        int base;
        int total;
        repeat (4) @(posedge aclk);
        rst_n <= 1'b1;

        base = errs_init;
        repeat (20) begin
            @(posedge net_clk);
            if (net_req_valid || net_rd_data_valid || rd_cmd_valid != '0) begin
                $display("a valid output went high with no input offered");
                errs_init++;
            end
        end
        report("reset", errs_init - base + errs_req);

        // All regions present at the same edge and keep requesting
        base = errs_req;
        fair_mode = 1'b1;
        @(negedge aclk);
        load_requests(N_FAIR);
        while (requests_pending()) @(posedge net_clk);
        fair_mode = 1'b0;
        report("fairness", errs_req - base);

        base = errs_req;
        throttle = 1'b1;
        @(negedge aclk);
        load_requests(N_REQ);
        while (requests_pending()) @(posedge net_clk);
        report("request crossing", errs_req - base);

        @(negedge net_clk);
        load_commands();
        while (requests_pending()) @(posedge net_clk);
        report("command routing", errs_cmd);
        report("ordered data return", errs_data);

        // Nothing repeated or left behind after the drain
        base = errs_init + errs_req + errs_data + errs_cmd;
        repeat (40) @(posedge net_clk);
        for (int i = 0; i < `N_REGIONS; i++) begin
            if (host_q[i].size() > 0 || region_q[i].size() > 0) begin
                $display("region %0d still holds unsent items", i);
                errs_init++;
            end
        end
        total = errs_init + errs_req + errs_data + errs_cmd;
        report("back-pressure", total - base);

        $display("%0d tests run, %0d failed, %0d errors", n_tests, n_failed, total);
        if (n_failed == 0 && total == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        #(WD_TIME);
        $display("timeout: outputs still pending at %0t", $time);
        $display("Testbench failed");
        $finish;
    end

endmodule

/* sources.f */
+incdir+rtl
rtl/net_cross_pkg.sv
rtl/async_stream_fifo.sv
rtl/req_arbiter.sv
rtl/rd_cmd_router.sv
rtl/network_clk_cross.sv
test/network_clk_cross_sva.sv
test/network_clk_cross_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module network_clk_cross_tb -o sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^Testbench passed$"; then
    exit 0
fi
exit 1
